/* include/dac_macros.svh */
`ifndef DAC_MACROS_SVH
`define DAC_MACROS_SVH

// Sample and batch geometry
`define DAC_SAMPLE_WIDTH      16
`define DAC_SAMPLES_PER_BATCH 4

// PS register bus, byte addresses
`define A_BUS_WIDTH  8
`define WD_BUS_WIDTH 32

// DMA segment word and wave memory depth (64 lines)
`define DMA_DATA_WIDTH  48
`define WAVE_ADDR_WIDTH 6

// Register map
`define REG_CTRL    8'h00
`define REG_STATUS  8'h04
`define REG_BATCHES 8'h08

// Response codes
`define RESP_OKAY   2'd0
`define RESP_SLVERR 2'd2

`endif

/* hdl/dac_sys_pkg.sv */
`include "dac_macros.svh"

package dac_sys_pkg;

    typedef logic [`DAC_SAMPLE_WIDTH-1:0] sample_t;
    // Sample 0 sits in the low bits
    typedef logic [`DAC_SAMPLES_PER_BATCH*`DAC_SAMPLE_WIDTH-1:0] batch_t;
    typedef logic [`A_BUS_WIDTH-1:0] reg_addr_t;
    typedef logic [`WD_BUS_WIDTH-1:0] reg_data_t;
    typedef logic [`WAVE_ADDR_WIDTH-1:0] wave_addr_t;
    // One bit wider than the address so a full memory can be counted
    typedef logic [`WAVE_ADDR_WIDTH:0] line_count_t;
    typedef logic [1:0] resp_t;

    // One DMA word, duration counted in batches
    typedef struct packed {
        sample_t                             start;
        logic signed [`DAC_SAMPLE_WIDTH-1:0] slope;
        logic [15:0]                         duration;
    } pwl_seg_t;

    typedef struct packed {
        logic run;
        logic pl_reset;
    } dac_ctrl_t;

    typedef struct packed {
        logic        done;
        logic        running;
        line_count_t lines_stored;
        reg_data_t   batches_sent;
    } dac_status_t;

    typedef enum logic [1:0] {DAC_IDLE, DAC_RUN, DAC_DONE} dac_state_e;
    typedef enum logic [1:0] {PWL_IDLE, PWL_FETCH, PWL_PLAY} pwl_state_e;

endpackage

/* hdl/ps_reg_slave.sv */
`timescale 1ns/1ps
`include "dac_macros.svh"

module ps_reg_slave (
    input  wire                     clk,
    input  wire                     rst_n,
    input  dac_sys_pkg::reg_addr_t  raddr_packet,
    input  wire                     raddr_valid_packet,
    input  dac_sys_pkg::reg_addr_t  waddr_packet,
    input  wire                     waddr_valid_packet,
    input  dac_sys_pkg::reg_data_t  wdata_packet,
    input  wire                     wdata_valid_packet,
    input  wire                     ps_wresp_rdy,
    input  wire                     ps_read_rdy,
    output dac_sys_pkg::resp_t      wresp_out,
    output dac_sys_pkg::resp_t      rresp_out,
    output logic                    wresp_valid_out,
    output logic                    rresp_valid_out,
    output dac_sys_pkg::reg_data_t  rdata_packet,
    output logic                    rdata_valid_out,
    output dac_sys_pkg::dac_ctrl_t  ctrl,
    input  dac_sys_pkg::dac_status_t status,
    output logic                    pl_rstn
);

    dac_sys_pkg::reg_addr_t waddr_q;
    dac_sys_pkg::reg_data_t wdata_q;
    dac_sys_pkg::reg_data_t rd_mux;
    logic                   waddr_held;
    logic                   wdata_held;
    logic                   wr_fire;

    function automatic logic addr_known(dac_sys_pkg::reg_addr_t a);
        return (a == `REG_CTRL) || (a == `REG_STATUS) || (a == `REG_BATCHES);
    endfunction

    assign wr_fire = waddr_held && wdata_held;
    assign pl_rstn = ~ctrl.pl_reset;
    // Read data and read response share one handshake
    assign rresp_valid_out = rdata_valid_out;

    always_comb begin
        case (raddr_packet)
            `REG_CTRL:    rd_mux = dac_sys_pkg::reg_data_t'({ctrl.pl_reset, ctrl.run});
            // Running flag in the top bit
            `REG_STATUS:  rd_mux = {status.running,
                                    {(`WD_BUS_WIDTH-1-$bits(status.lines_stored)){1'b0}},
                                    status.lines_stored};
            `REG_BATCHES: rd_mux = status.batches_sent;
            default:      rd_mux = '0;
        endcase
    end

    // Address and data halves arrive independently
    always_ff @(posedge clk) begin
        if (waddr_valid_packet) begin
            waddr_q <= waddr_packet;
        end
        if (wdata_valid_packet) begin
            wdata_q <= wdata_packet;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waddr_held      <= 1'b0;
            wdata_held      <= 1'b0;
            wresp_valid_out <= 1'b0;
            wresp_out       <= `RESP_OKAY;
            ctrl            <= '{run: 1'b0, pl_reset: 1'b1};
        end else begin
            if (wr_fire) begin
                waddr_held      <= 1'b0;
                wdata_held      <= 1'b0;
                wresp_valid_out <= 1'b1;
                wresp_out       <= addr_known(waddr_q) ? `RESP_OKAY : `RESP_SLVERR;
            end else if (wresp_valid_out && ps_wresp_rdy) begin
                wresp_valid_out <= 1'b0;
            end
            if (waddr_valid_packet) begin
                waddr_held <= 1'b1;
            end
            if (wdata_valid_packet) begin
                wdata_held <= 1'b1;
            end
            // Playback end drops run, a CTRL write in the same cycle wins
            if (status.done) begin
                ctrl.run <= 1'b0;
            end
            if (wr_fire && waddr_q == `REG_CTRL) begin
                ctrl.run      <= wdata_q[0];
                ctrl.pl_reset <= wdata_q[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (raddr_valid_packet) begin
            rdata_packet <= rd_mux;
            rresp_out    <= addr_known(raddr_packet) ? `RESP_OKAY : `RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid_out <= 1'b0;
        end else if (raddr_valid_packet) begin
            rdata_valid_out <= 1'b1;
        end else if (rdata_valid_out && ps_read_rdy) begin
            rdata_valid_out <= 1'b0;
        end
    end

endmodule

/* hdl/pwl_wave_store.sv */
`timescale 1ns/1ps
`include "dac_macros.svh"

module pwl_wave_store (
    input  wire                       clk,
    input  wire                       rst_n,
    input  dac_sys_pkg::pwl_seg_t     pwl_tdata,
    input  wire                       pwl_tvalid,
    input  wire                       pwl_tlast,
    output logic                      pwl_tready,
    input  wire                       busy,
    input  dac_sys_pkg::wave_addr_t   rd_addr,
    output dac_sys_pkg::pwl_seg_t     rd_seg,
    output dac_sys_pkg::line_count_t  lines_stored
);

    dac_sys_pkg::pwl_seg_t    mem [0:(1 << `WAVE_ADDR_WIDTH)-1];
    dac_sys_pkg::line_count_t wr_ptr;
    logic                     full;
    logic                     beat;

    // Pointer reaches the depth only when a packet overruns the memory
    assign full       = wr_ptr[`WAVE_ADDR_WIDTH];
    assign pwl_tready = !busy && !full;
    assign beat       = pwl_tvalid && pwl_tready;

    always_ff @(posedge clk) begin
        if (beat) begin
            mem[wr_ptr[`WAVE_ADDR_WIDTH-1:0]] <= pwl_tdata;
        end
        rd_seg <= mem[rd_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            lines_stored <= '0;
        end else if (beat) begin
            if (pwl_tlast) begin
                // Next packet starts again at line 0
                wr_ptr       <= '0;
                lines_stored <= wr_ptr + 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

/* hdl/pwl_gen.sv */
`timescale 1ns/1ps
`include "dac_macros.svh"

module pwl_gen (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  dac_sys_pkg::line_count_t  lines,
    output dac_sys_pkg::wave_addr_t   rd_addr,
    input  dac_sys_pkg::pwl_seg_t     rd_seg,
    output dac_sys_pkg::batch_t       dac_batch,
    output logic                      valid_dac_batch,
    input  wire                       dac0_rdy,
    output logic                      finished
);

    dac_sys_pkg::pwl_state_e  pwlState;
    // Index of the next segment to load, rd_seg always holds that line
    dac_sys_pkg::wave_addr_t  seg_addr;
    dac_sys_pkg::line_count_t segs_left;
    logic [15:0]              batches_left;
    dac_sys_pkg::sample_t     value_q;
    // Two's complement slope, wraps the same as the signed value
    dac_sys_pkg::sample_t     slope_q;
    logic                     taken;
    logic                     last_batch;
    logic                     load;
    logic                     skip;

    assign valid_dac_batch = (pwlState == dac_sys_pkg::PWL_PLAY);
    assign taken           = valid_dac_batch && dac0_rdy;
    assign last_batch      = (batches_left == 16'd1);
    assign finished        = (pwlState == dac_sys_pkg::PWL_FETCH) && (segs_left == '0);

    // Zero-duration segments are skipped in FETCH
    always_comb begin
        load = 1'b0;
        skip = 1'b0;
        case (pwlState)
            dac_sys_pkg::PWL_FETCH: begin
                if (segs_left != '0) begin
                    load = (rd_seg.duration != '0);
                    skip = (rd_seg.duration == '0);
                end
            end
            // Prefetched segment goes straight in behind the last batch
            dac_sys_pkg::PWL_PLAY: begin
                load = taken && last_batch && (segs_left != '0) && (rd_seg.duration != '0);
            end
            default: begin
                load = 1'b0;
            end
        endcase
    end

    // Address of the next cycle, so the memory output tracks seg_addr
    always_comb begin
        if (finished) begin
            rd_addr = '0;
        end else if (load || skip) begin
            rd_addr = seg_addr + 1'b1;
        end else begin
            rd_addr = seg_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwlState     <= dac_sys_pkg::PWL_IDLE;
            seg_addr     <= '0;
            segs_left    <= '0;
            batches_left <= '0;
        end else begin
            seg_addr <= rd_addr;
            if (load || skip) begin
                segs_left <= segs_left - 1'b1;
            end
            if (load) begin
                batches_left <= rd_seg.duration;
            end else if (taken) begin
                batches_left <= batches_left - 1'b1;
            end
            case (pwlState)
                dac_sys_pkg::PWL_IDLE: begin
                    if (start) begin
                        segs_left <= lines;
                        pwlState  <= dac_sys_pkg::PWL_FETCH;
                    end
                end
                dac_sys_pkg::PWL_FETCH: begin
                    if (finished) begin
                        pwlState <= dac_sys_pkg::PWL_IDLE;
                    end else if (load) begin
                        pwlState <= dac_sys_pkg::PWL_PLAY;
                    end
                end
                dac_sys_pkg::PWL_PLAY: begin
                    if (taken && last_batch && !load) begin
                        pwlState <= dac_sys_pkg::PWL_FETCH;
                    end
                end
                default: begin
                    pwlState <= dac_sys_pkg::PWL_IDLE;
                end
            endcase
        end
    end

    // Running value advances by four slopes per taken batch
    always_ff @(posedge clk) begin
        if (load) begin
            value_q <= rd_seg.start;
            slope_q <= rd_seg.slope;
        end else if (taken) begin
            value_q <= value_q + slope_q * dac_sys_pkg::sample_t'(`DAC_SAMPLES_PER_BATCH);
        end
    end

    always_comb begin
        for (int k = 0; k < `DAC_SAMPLES_PER_BATCH; k++) begin
            dac_batch[k*`DAC_SAMPLE_WIDTH +: `DAC_SAMPLE_WIDTH] =
                value_q + slope_q * dac_sys_pkg::sample_t'(k);
        end
    end

endmodule

/* hdl/dac_intf.sv */
`timescale 1ns/1ps

module dac_intf (
    input  wire                       clk,
    input  wire                       rst_n,
    input  dac_sys_pkg::dac_ctrl_t    ctrl,
    output dac_sys_pkg::dac_status_t  status,
    input  dac_sys_pkg::pwl_seg_t     pwl_tdata,
    input  wire                       pwl_tvalid,
    input  wire                       pwl_tlast,
    output logic                      pwl_tready,
    output dac_sys_pkg::batch_t       dac_batch,
    output logic                      valid_dac_batch,
    input  wire                       dac0_rdy
);

    dac_sys_pkg::dac_state_e  dacState;
    dac_sys_pkg::wave_addr_t  rd_addr;
    dac_sys_pkg::pwl_seg_t    rd_seg;
    dac_sys_pkg::line_count_t lines_stored;
    dac_sys_pkg::reg_data_t   batches_sent;
    logic                     gen_start;
    logic                     gen_finished;
    logic                     busy;

    assign gen_start = (dacState == dac_sys_pkg::DAC_IDLE) && ctrl.run;
    // Memory is locked from the moment run is set
    assign busy      = (dacState != dac_sys_pkg::DAC_IDLE) || ctrl.run;

    assign status = '{done:         (dacState == dac_sys_pkg::DAC_DONE),
                      running:      (dacState == dac_sys_pkg::DAC_RUN),
                      lines_stored: lines_stored,
                      batches_sent: batches_sent};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dacState     <= dac_sys_pkg::DAC_IDLE;
            batches_sent <= '0;
        end else begin
            if (gen_start) begin
                batches_sent <= '0;
            end else if (valid_dac_batch && dac0_rdy) begin
                batches_sent <= batches_sent + 1'b1;
            end
            case (dacState)
                dac_sys_pkg::DAC_IDLE: begin
                    if (ctrl.run) begin
                        dacState <= dac_sys_pkg::DAC_RUN;
                    end
                end
                dac_sys_pkg::DAC_RUN: begin
                    if (gen_finished) begin
                        dacState <= dac_sys_pkg::DAC_DONE;
                    end
                end
                // One-cycle done pulse, the slave drops run here
                default: begin
                    dacState <= dac_sys_pkg::DAC_IDLE;
                end
            endcase
        end
    end

    pwl_wave_store pwl_wave_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .pwl_tdata    (pwl_tdata),
        .pwl_tvalid   (pwl_tvalid),
        .pwl_tlast    (pwl_tlast),
        .pwl_tready   (pwl_tready),
        .busy         (busy),
        .rd_addr      (rd_addr),
        .rd_seg       (rd_seg),
        .lines_stored (lines_stored)
    );

    pwl_gen pwl_gen (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (gen_start),
        .lines           (lines_stored),
        .rd_addr         (rd_addr),
        .rd_seg          (rd_seg),
        .dac_batch       (dac_batch),
        .valid_dac_batch (valid_dac_batch),
        .dac0_rdy        (dac0_rdy),
        .finished        (gen_finished)
    );

endmodule

/* hdl/dac_top.sv */
`timescale 1ns/1ps

module dac_top (
    input  wire                      clk,
    input  wire                      rst_n,
    // DAC side
    input  wire                      dac0_rdy,
    output dac_sys_pkg::batch_t      dac_batch,
    output logic                     valid_dac_batch,
    output logic                     pl_rstn,
    // PS request channels
    input  dac_sys_pkg::reg_addr_t   raddr_packet,
    input  wire                      raddr_valid_packet,
    input  dac_sys_pkg::reg_addr_t   waddr_packet,
    input  wire                      waddr_valid_packet,
    input  dac_sys_pkg::reg_data_t   wdata_packet,
    input  wire                      wdata_valid_packet,
    input  wire                      ps_wresp_rdy,
    input  wire                      ps_read_rdy,
    // PS responses
    output dac_sys_pkg::resp_t       wresp_out,
    output dac_sys_pkg::resp_t       rresp_out,
    output logic                     wresp_valid_out,
    output logic                     rresp_valid_out,
    output dac_sys_pkg::reg_data_t   rdata_packet,
    output logic                     rdata_valid_out,
    // DMA segment stream
    input  dac_sys_pkg::pwl_seg_t    pwl_tdata,
    input  wire                      pwl_tlast,
    input  wire                      pwl_tvalid,
    output logic                     pwl_tready
);

    dac_sys_pkg::dac_ctrl_t   ctrl;
    dac_sys_pkg::dac_status_t status;

    ps_reg_slave ps_reg_slave (
        .clk                (clk),
        .rst_n              (rst_n),
        .raddr_packet       (raddr_packet),
        .raddr_valid_packet (raddr_valid_packet),
        .waddr_packet       (waddr_packet),
        .waddr_valid_packet (waddr_valid_packet),
        .wdata_packet       (wdata_packet),
        .wdata_valid_packet (wdata_valid_packet),
        .ps_wresp_rdy       (ps_wresp_rdy),
        .ps_read_rdy        (ps_read_rdy),
        .wresp_out          (wresp_out),
        .rresp_out          (rresp_out),
        .wresp_valid_out    (wresp_valid_out),
        .rresp_valid_out    (rresp_valid_out),
        .rdata_packet       (rdata_packet),
        .rdata_valid_out    (rdata_valid_out),
        .ctrl               (ctrl),
        .status             (status),
        .pl_rstn            (pl_rstn)
    );

    dac_intf dac_intf (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl            (ctrl),
        .status          (status),
        .pwl_tdata       (pwl_tdata),
        .pwl_tvalid      (pwl_tvalid),
        .pwl_tlast       (pwl_tlast),
        .pwl_tready      (pwl_tready),
        .dac_batch       (dac_batch),
        .valid_dac_batch (valid_dac_batch),
        .dac0_rdy        (dac0_rdy)
    );

endmodule

/* tb/dac_top_assert.sv */
`timescale 1ns/1ps

module dac_top_assert (
    input wire                 clk,
    input wire                 rst_n,
    input wire                 dac0_rdy,
    input wire                 valid_dac_batch,
    input dac_sys_pkg::batch_t dac_batch,
    input wire                 wresp_valid_out,
    input wire                 ps_wresp_rdy,
    input wire                 rdata_valid_out,
    input wire                 rresp_valid_out,
    input wire                 ps_read_rdy,
    input wire                 pwl_tready
);

    // A batch that is not taken stays on the bus unchanged
    batch_held: assert property (@(posedge clk) disable iff (!rst_n)
        valid_dac_batch && !dac0_rdy |=> valid_dac_batch && $stable(dac_batch))
        else $error("DAC batch dropped or changed before dac0_rdy");

    wresp_held: assert property (@(posedge clk) disable iff (!rst_n)
        wresp_valid_out && !ps_wresp_rdy |=> wresp_valid_out)
        else $error("Write response dropped before ps_wresp_rdy");

    rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid_out && !ps_read_rdy |=> rdata_valid_out)
        else $error("Read data dropped before ps_read_rdy");

    rresp_held: assert property (@(posedge clk) disable iff (!rst_n)
        rresp_valid_out && !ps_read_rdy |=> rresp_valid_out)
        else $error("Read response dropped before ps_read_rdy");

    // Wave memory is locked during playback
    tready_locked: assert property (@(posedge clk) disable iff (!rst_n)
        valid_dac_batch |-> !pwl_tready)
        else $error("pwl_tready high while a batch is valid");

endmodule

bind dac_top dac_top_assert assert_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .dac0_rdy        (dac0_rdy),
    .valid_dac_batch (valid_dac_batch),
    .dac_batch       (dac_batch),
    .wresp_valid_out (wresp_valid_out),
    .ps_wresp_rdy    (ps_wresp_rdy),
    .rdata_valid_out (rdata_valid_out),
    .rresp_valid_out (rresp_valid_out),
    .ps_read_rdy     (ps_read_rdy),
    .pwl_tready      (pwl_tready)
);

/* tb/dac_top_tb.sv */
`timescale 1ns/1ps
`include "dac_macros.svh"

module dac_top_tb;

    localparam int wait_limit = 2000;

    logic clk = 1'b0;
    logic rst_n;
    logic dac0_rdy;
    logic raddr_valid_packet;
    logic waddr_valid_packet;
    logic wdata_valid_packet;
    logic ps_wresp_rdy;
    logic ps_read_rdy;
    logic pwl_tlast;
    logic pwl_tvalid;
    logic pwl_tready;
    logic valid_dac_batch;
    logic pl_rstn;
    logic wresp_valid_out;
    logic rresp_valid_out;
    logic rdata_valid_out;
    dac_sys_pkg::reg_addr_t  raddr_packet;
    dac_sys_pkg::reg_addr_t  waddr_packet;
    dac_sys_pkg::reg_data_t  wdata_packet;
    dac_sys_pkg::reg_data_t  rdata_packet;
    dac_sys_pkg::resp_t      wresp_out;
    dac_sys_pkg::resp_t      rresp_out;
    dac_sys_pkg::batch_t     dac_batch;
    dac_sys_pkg::pwl_seg_t   pwl_tdata;

    // Reference copy of what the wave memory should hold
    dac_sys_pkg::pwl_seg_t model_mem [0:(1 << `WAVE_ADDR_WIDTH)-1];
    int          model_lines = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] lfsr = 32'h607e;

    dac_top dut_i (.*);

    always #2 clk = ~clk;

    // Galois LFSR, one step per bit
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = b ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        assert (exp_v == act_v) else begin
            $display("FAILED %s expected %0h actual %0h", name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic stall(input string what);
        $display("Timed out waiting for %s", what);
        timeouts++;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic write_reg(input dac_sys_pkg::reg_addr_t addr,
                             input dac_sys_pkg::reg_data_t data,
                             input dac_sys_pkg::resp_t exp_resp);
        int t;
        ps_wresp_rdy       = 1'b0;
        waddr_packet       = addr;
        wdata_packet       = data;
        waddr_valid_packet = 1'b1;
        wdata_valid_packet = 1'b1;
        @(negedge clk);
        waddr_valid_packet = 1'b0;
        wdata_valid_packet = 1'b0;
        t = 0;
        while (!wresp_valid_out && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!wresp_valid_out) begin
            stall("write response");
        end
        check_val("write response", 64'(exp_resp), 64'(wresp_out));
        // Hold the response back for a few cycles
        repeat (rand_bits(2)) @(negedge clk);
        ps_wresp_rdy = 1'b1;
        @(negedge clk);
    endtask

    task automatic read_reg(input dac_sys_pkg::reg_addr_t addr,
                            output dac_sys_pkg::reg_data_t data,
                            output dac_sys_pkg::resp_t resp);
        int t;
        ps_read_rdy        = 1'b0;
        raddr_packet       = addr;
        raddr_valid_packet = 1'b1;
        @(negedge clk);
        raddr_valid_packet = 1'b0;
        t = 0;
        while (!rdata_valid_out && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!rdata_valid_out) begin
            stall("read data");
        end
        // Read response comes back together with the read data
        check_val("read response valid", 64'd1, 64'(rresp_valid_out));
        data = rdata_packet;
        resp = rresp_out;
        repeat (rand_bits(2)) @(negedge clk);
        ps_read_rdy = 1'b1;
        @(negedge clk);
    endtask

    task automatic expect_read(input string name, input dac_sys_pkg::reg_addr_t addr,
                               input dac_sys_pkg::reg_data_t exp_data,
                               input dac_sys_pkg::resp_t exp_resp);
        dac_sys_pkg::reg_data_t data;
        dac_sys_pkg::resp_t     resp;
        read_reg(addr, data, resp);
        check_val(name, 64'(exp_data), 64'(data));
        check_val({name, " response"}, 64'(exp_resp), 64'(resp));
    endtask

    task automatic send_packet(input int n);
        dac_sys_pkg::pwl_seg_t seg;
        int                    t;
        for (int i = 0; i < n; i++) begin
            seg.start    = dac_sys_pkg::sample_t'(rand_bits(16));
            seg.slope    = 16'(rand_bits(16));
            seg.duration = 16'(rand_bits(3));
            model_mem[i] = seg;
            t = 0;
            while (!pwl_tready && t < wait_limit) begin
                @(negedge clk);
                t++;
            end
            if (!pwl_tready) begin
                stall("pwl_tready");
            end
            pwl_tdata  = seg;
            pwl_tvalid = 1'b1;
            pwl_tlast  = (i == n - 1);
            @(negedge clk);
        end
        pwl_tvalid  = 1'b0;
        pwl_tlast   = 1'b0;
        model_lines = n;
    endtask

    task automatic play(input logic random_rdy);
        dac_sys_pkg::batch_t    exp_q [$];
        dac_sys_pkg::batch_t    exp_b;
        dac_sys_pkg::reg_data_t data;
        dac_sys_pkg::resp_t     resp;
        int                     v;
        int                     got;
        int                     t;
        // Sample k of batch n is start + slope * (4n + k)
        for (int i = 0; i < model_lines; i++) begin
            for (int n = 0; n < int'(model_mem[i].duration); n++) begin
                for (int k = 0; k < `DAC_SAMPLES_PER_BATCH; k++) begin
                    v = int'(model_mem[i].start) + int'($signed(model_mem[i].slope))
                        * (`DAC_SAMPLES_PER_BATCH * n + k);
                    exp_b[k*`DAC_SAMPLE_WIDTH +: `DAC_SAMPLE_WIDTH] = dac_sys_pkg::sample_t'(v);
                end
                exp_q.push_back(exp_b);
            end
        end
        dac0_rdy = 1'b0;
        write_reg(`REG_CTRL, 32'h1, `RESP_OKAY);
        got = 0;
        t   = 0;
        while (got < exp_q.size() && t < wait_limit) begin
            dac0_rdy = random_rdy ? rand_bit() : 1'b1;
            if (valid_dac_batch && dac0_rdy) begin
                check_val("batch", exp_q[got], dac_batch);
                got++;
            end
            @(negedge clk);
            t++;
        end
        if (got < exp_q.size()) begin
            stall("DAC batches");
        end
        // Any extra batch would be taken now and show up in BATCHES
        dac0_rdy = 1'b1;
        data     = 32'h1;
        t        = 0;
        while (data[0] && t < 100) begin
            read_reg(`REG_CTRL, data, resp);
            assert (!valid_dac_batch) else begin
                $display("Batch valid after the expected sequence ended");
                errors++;
            end
            t++;
        end
        if (data[0]) begin
            stall("run to clear");
        end
        check_val("CTRL after playback", 64'd0, 64'(data));
        expect_read("BATCHES", `REG_BATCHES, dac_sys_pkg::reg_data_t'(exp_q.size()), `RESP_OKAY);
        assert (pwl_tready) else begin
            $display("pwl_tready stayed low after playback");
            errors++;
        end
    endtask

    initial begin
        logic b;
        int   n1;
        int   n2;
        rst_n              = 1'b0;
        dac0_rdy           = 1'b0;
        raddr_packet       = '0;
        raddr_valid_packet = 1'b0;
        waddr_packet       = '0;
        waddr_valid_packet = 1'b0;
        wdata_packet       = '0;
        wdata_valid_packet = 1'b0;
        ps_wresp_rdy       = 1'b1;
        ps_read_rdy        = 1'b1;
        pwl_tdata          = '0;
        pwl_tlast          = 1'b0;
        pwl_tvalid         = 1'b0;
        apply_reset();
        check_val("pl_rstn after reset", 64'd0, 64'(pl_rstn));
        check_val("pwl_tready after reset", 64'd1, 64'(pwl_tready));

        // Register access and pl_rstn
        for (int i = 0; i < 4; i++) begin
            b = rand_bit();
            write_reg(`REG_CTRL, dac_sys_pkg::reg_data_t'({b, 1'b0}), `RESP_OKAY);
            expect_read("CTRL readback", `REG_CTRL, dac_sys_pkg::reg_data_t'({b, 1'b0}),
                        `RESP_OKAY);
            check_val("pl_rstn", 64'(!b), 64'(pl_rstn));
        end
        write_reg(`REG_CTRL, 32'h0, `RESP_OKAY);
        write_reg(8'h10, 32'h1234_5678, `RESP_SLVERR);
        expect_read("unknown address", 8'h10, 32'h0, `RESP_SLVERR);

        // Two packets, the shorter one replaces the count
        n1 = 1 + int'(rand_bits(5) % 20);
        send_packet(n1);
        expect_read("STATUS first packet", `REG_STATUS, dac_sys_pkg::reg_data_t'(n1), `RESP_OKAY);
        n2 = (n1 > 1) ? 1 + int'(rand_bits(5) % 32'(n1 - 1)) : 1;
        send_packet(n2);
        expect_read("STATUS second packet", `REG_STATUS, dac_sys_pkg::reg_data_t'(n2), `RESP_OKAY);

        play(1'b0);
        play(1'b1);

        // Empty memory after a fresh reset
        apply_reset();
        model_lines = 0;
        expect_read("STATUS after reset", `REG_STATUS, 32'h0, `RESP_OKAY);
        write_reg(`REG_CTRL, 32'h0, `RESP_OKAY);
        play(1'b0);

        $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
hdl/dac_sys_pkg.sv
hdl/ps_reg_slave.sv
hdl/pwl_wave_store.sv
hdl/pwl_gen.sv
hdl/dac_intf.sv
hdl/dac_top.sv
tb/dac_top_assert.sv
tb/dac_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DAC subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module dac_top_tb -o sim_dac \
    && ./obj_dir/sim_dac > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "ERRORS FOUND" sim.log \
    && echo "Simulation passed" \
    || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
